//--- Bender.yml
package:
  name: upd7800_periph

sources:
  - upd7800_pkg.sv
  - int_sampler.sv
  - int_ctrl.sv
  - timer_unit.sv
  - io_ports.sv
  - spr_file.sv
  - upd7800_periph.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - upd7800_periph_assert.sv
      - upd7800_periph_tb.sv

//--- int_ctrl.sv
////////////////////////////////////////
// Interrupt controller
// Pending, mask, fetch latch, priority and vector
////////////////////////////////////////
`default_nettype none

module int_ctrl (
  input  logic                              CLK,
  input  logic                              arst_n,
  input  logic                              cp1p,
  input  logic                              int0,
  input  logic                              int1,
  input  logic                              int2,
  input  logic                              tm_uf,
  input  logic [upd7800_pkg::data_w-1:0]    mk,
  input  logic                              ie,
  input  logic                              fetch_start,
  input  logic                              int_ack,
  input  upd7800_pkg::int_idx_e             irf_sel,
  input  logic                              irf_clr,
  output logic                              irf_hit,
  output logic                              int_req,
  output logic [upd7800_pkg::data_w-1:0]    int_vector
);

  import upd7800_pkg::*;

  logic [3:0]           div_cnt;
  logic                 tick;
  logic                 int1_edge;
  logic                 int2_edge;
  logic                 int2_pin;
  logic [int_vec_w-1:0] pend;
  logic [int_vec_w-1:0] latch;
  logic [int_vec_w-1:0] en;
  logic [int_vec_w-1:0] set_v;
  logic [int_vec_w-1:0] clr_v;
  logic [int_vec_w-1:0] ack_mask;
  logic [int_vec_w-1:0] irf_mask;
  int_idx_e             win_idx;
  logic [data_w-1:0]    win_vec;

  ////////////////////////////////////////
  // Divide-by-12 sampling tick

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= 4'd0;
    end else if (cp1p) begin
      div_cnt <= (div_cnt == 4'(div12_last)) ? 4'd0 : div_cnt + 4'd1;
    end
  end

  assign tick = cp1p & (div_cnt == 4'(div12_last));

  // MK bit 5 picks the INT2 edge, 0 means falling
  assign int2_pin = int2 ^ ~mk[5];

  int_sampler u_int1 (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .tick      (tick),
    .pin       (int1),
    .edge_seen (int1_edge)
  );

  int_sampler u_int2 (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .tick      (tick),
    .pin       (int2_pin),
    .edge_seen (int2_edge)
  );

  ////////////////////////////////////////
  // Pending and fetch latch

  // Mask bits line up with the index order
  assign en = {int_vec_w{ie}} & ~mk[int_vec_w-1:0];

  always_comb begin
    win_idx = INT_0;
    for (int i = int_vec_w - 1; i >= 0; i--) begin
      if (latch[i]) begin
        win_idx = int_idx_e'(i);
      end
    end
  end

  assign ack_mask = (int_ack & int_req) ? (int_vec_w'(1) << win_idx) : '0;
  assign irf_mask = irf_clr ? (int_vec_w'(1) << irf_sel) : '0;

  always_comb begin
    set_v = '0;
    set_v[INT_0] = int0 & ~pend[INT_0];
    set_v[INT_T] = tm_uf;
    set_v[INT_1] = int1_edge;
    set_v[INT_2] = int2_edge;
    clr_v = ack_mask | irf_mask;
    // INT0 is a level source
    clr_v[INT_0] = clr_v[INT_0] | ~int0;
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pend  <= '0;
      latch <= '0;
    end else begin
      pend <= (pend & ~clr_v) | set_v;
      if (fetch_start) begin
        latch <= pend & en;
      end else begin
        latch <= latch & ~ack_mask;
      end
    end
  end

  ////////////////////////////////////////
  // Vector and flag test

  always_comb begin
    unique case (win_idx)
      INT_0:   win_vec = vec_int0;
      INT_T:   win_vec = vec_intt;
      INT_1:   win_vec = vec_int1;
      default: win_vec = vec_int2;
    endcase
  end

  assign int_req    = |latch;
  assign int_vector = int_req ? win_vec : '0;
  assign irf_hit    = pend[irf_sel];

endmodule

`default_nettype wire

//--- int_sampler.sv
////////////////////////////////////////
// Edge interrupt pin sampler
// Glitch filter on the divide-by-12 tick
////////////////////////////////////////
`default_nettype none

module int_sampler (
  input  logic CLK,
  input  logic arst_n,
  input  logic tick,
  input  logic pin,
  output logic edge_seen
);

  // Oldest sample in bit 3
  logic [3:0] hist;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      hist <= 4'b0000;
    end else if (tick) begin
      hist <= {hist[2:0], pin};
    end
  end

  // One low then three highs
  assign edge_seen = tick & (hist == 4'b0111);

endmodule

`default_nettype wire

//--- io_ports.sv
////////////////////////////////////////
// Ports A, B and C
// Output latches, mode registers and read-back
////////////////////////////////////////
`default_nettype none

module io_ports (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  upd7800_pkg::spr_wr_t           spr_wr,
  input  logic [upd7800_pkg::data_w-1:0] pb_in,
  input  logic [upd7800_pkg::data_w-1:0] pc_in,
  output upd7800_pkg::port_out_t         port_out,
  output upd7800_pkg::port_rd_t          port_rd
);

  import upd7800_pkg::*;

  logic [data_w-1:0] pa;
  logic [data_w-1:0] pb;
  logic [data_w-1:0] pc;
  logic [data_w-1:0] mb;
  logic [data_w-1:0] mc;
  logic [data_w-1:0] pb_oe;
  logic [data_w-1:0] pc_oe;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pa <= '0;
      pb <= '0;
      pc <= '0;
      mb <= '1;
      mc <= '1;
    end else if (spr_wr.we) begin
      case (spr_wr.sel)
        SPR_PA:  pa <= spr_wr.data;
        SPR_PB:  pb <= spr_wr.data;
        SPR_PC:  pc <= spr_wr.data;
        SPR_MB:  mb <= spr_wr.data;
        SPR_MC:  mc <= spr_wr.data;
        default: ;
      endcase
    end
  end

  // Mode bit 1 means input
  assign pb_oe = ~mb;
  // Only bits 7, 1 and 0 of port C follow MC
  assign pc_oe = {~mc[7], pc_fixed_oe, ~mc[1:0]};

  assign port_out = '{pa: pa, pb: pb, pb_oe: pb_oe, pc: pc, pc_oe: pc_oe};

  // Pins for inputs, latch for outputs
  assign port_rd.pa = pa;
  assign port_rd.pb = (pb_in & ~pb_oe) | (pb & pb_oe);
  assign port_rd.pc = (pc_in & ~pc_oe) | (pc & pc_oe);
  assign port_rd.mb = mb;
  assign port_rd.mc = mc;

endmodule

`default_nettype wire

//--- spr_file.sv
////////////////////////////////////////
// Special-register file
// Interrupt mask and read mux
////////////////////////////////////////
`default_nettype none

module spr_file (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  upd7800_pkg::spr_wr_t           spr_wr,
  input  upd7800_pkg::spr_e              spr_rd_sel,
  input  upd7800_pkg::port_rd_t          port_rd,
  input  logic [upd7800_pkg::tm_w-1:0]   tm_value,
  output logic [upd7800_pkg::data_w-1:0] mk,
  output logic [upd7800_pkg::data_w-1:0] spr_rd_data
);

  import upd7800_pkg::*;

  logic [data_w-1:0] mk_q;

  // All sources masked out of reset
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      mk_q <= '1;
    end else if (spr_wr.we && (spr_wr.sel == SPR_MK)) begin
      mk_q <= spr_wr.data;
    end
  end

  assign mk = mk_q;

  ////////////////////////////////////////
  // Read mux

  always_comb begin
    case (spr_rd_sel)
      SPR_PA:  spr_rd_data = port_rd.pa;
      SPR_PB:  spr_rd_data = port_rd.pb;
      SPR_PC:  spr_rd_data = port_rd.pc;
      SPR_MK:  spr_rd_data = mk_q;
      SPR_MB:  spr_rd_data = port_rd.mb;
      SPR_MC:  spr_rd_data = port_rd.mc;
      SPR_TM0: spr_rd_data = tm_value[7:0];
      // Upper reload nibble, zeros above
      SPR_TM1: spr_rd_data = {4'b0000, tm_value[tm_w-1:8]};
      default: spr_rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
////////////////////////////////////////
// Testbench clock and reset generator
////////////////////////////////////////
`default_nettype none

module tb_clock_gen #(
  parameter int period_ns    = 8,
  parameter int reset_cycles = 8
) (
  output logic CLK,
  output logic arst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    CLK = 1'b0;
    forever #(period_ns / 2) CLK = ~CLK;
  end

  // Release just after an edge, like the rest of the stimulus
  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge CLK);
    #1 arst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- timer_unit.sv
////////////////////////////////////////
// 12-bit reloadable timer
// Down-counter with a /8 prescaler
////////////////////////////////////////
`default_nettype none

module timer_unit (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  logic                           cp2n,
  input  logic                           stm,
  input  upd7800_pkg::spr_wr_t           spr_wr,
  output logic [upd7800_pkg::tm_w-1:0]   tm_value,
  output logic                           tm_uf
);

  import upd7800_pkg::*;

  logic [tm_w-1:0] tm;
  // Low 3 bits act as the prescaler
  logic [tc_w-1:0] tc;
  logic [tc_w-1:0] tc_reload;

  // Reload register, written a byte at a time
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      tm <= '1;
    end else if (spr_wr.we) begin
      case (spr_wr.sel)
        SPR_TM0: tm[7:0] <= spr_wr.data;
        SPR_TM1: tm[tm_w-1:8] <= spr_wr.data[3:0];
        default: ;
      endcase
    end
  end

  assign tc_reload = {tm, 3'b111};
  assign tm_uf     = cp2n & (tc == '0);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      tc <= '1;
    end else if (stm || tm_uf) begin
      // Restart also clears the prescaler
      tc <= tc_reload;
    end else if (cp2n) begin
      tc <= tc - 1'b1;
    end
  end

  assign tm_value = tm;

endmodule

`default_nettype wire

//--- upd7800_periph.sv
////////////////////////////////////////
// uPD7800 on-chip peripheral block
////////////////////////////////////////
`default_nettype none

module upd7800_periph (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  upd7800_pkg::spr_wr_t           spr_wr,
  input  upd7800_pkg::spr_e              spr_rd_sel,
  input  logic                           cp1p,
  input  logic                           cp2n,
  input  logic                           ie,
  input  logic                           fetch_start,
  input  logic                           int_ack,
  input  logic                           stm,
  input  upd7800_pkg::int_idx_e          irf_sel,
  input  logic                           irf_clr,
  input  logic                           int0,
  input  logic                           int1,
  input  logic                           int2,
  input  logic [upd7800_pkg::data_w-1:0] pb_in,
  input  logic [upd7800_pkg::data_w-1:0] pc_in,
  output upd7800_pkg::port_out_t         port_out,
  output logic [upd7800_pkg::data_w-1:0] spr_rd_data,
  output logic                           int_req,
  output logic [upd7800_pkg::data_w-1:0] int_vector,
  output logic                           irf_hit
);

  import upd7800_pkg::*;

  logic              tm_uf;
  logic [data_w-1:0] mk;
  logic [tm_w-1:0]   tm_value;
  port_rd_t          port_rd;

  int_ctrl u_int_ctrl (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .cp1p        (cp1p),
    .int0        (int0),
    .int1        (int1),
    .int2        (int2),
    .tm_uf       (tm_uf),
    .mk          (mk),
    .ie          (ie),
    .fetch_start (fetch_start),
    .int_ack     (int_ack),
    .irf_sel     (irf_sel),
    .irf_clr     (irf_clr),
    .irf_hit     (irf_hit),
    .int_req     (int_req),
    .int_vector  (int_vector)
  );

  timer_unit u_timer (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .cp2n     (cp2n),
    .stm      (stm),
    .spr_wr   (spr_wr),
    .tm_value (tm_value),
    .tm_uf    (tm_uf)
  );

  io_ports u_io_ports (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .spr_wr   (spr_wr),
    .pb_in    (pb_in),
    .pc_in    (pc_in),
    .port_out (port_out),
    .port_rd  (port_rd)
  );

  spr_file u_spr_file (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .spr_wr      (spr_wr),
    .spr_rd_sel  (spr_rd_sel),
    .port_rd     (port_rd),
    .tm_value    (tm_value),
    .mk          (mk),
    .spr_rd_data (spr_rd_data)
  );

endmodule

`default_nettype wire

//--- upd7800_periph_assert.sv
////////////////////////////////////////
// Assertions on the peripheral block
////////////////////////////////////////
`default_nettype none

module upd7800_periph_assert (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  logic                           int_req,
  input  logic [upd7800_pkg::data_w-1:0] int_vector,
  input  upd7800_pkg::port_out_t         port_out,
  input  logic                           tm_uf
);

  timeunit 1ns;
  timeprecision 100ps;

  import upd7800_pkg::*;

  // Number of failed assertions
  int fail_count = 0;

  // A request always carries one of the four fixed vectors
  vector_valid: assert property (
    @(posedge CLK) disable iff (!arst_n)
    int_req |-> ((int_vector == 8'h04) || (int_vector == 8'h08) ||
                 (int_vector == 8'h10) || (int_vector == 8'h20))
  ) else begin
    $error("int_vector %02h is not a valid vector", int_vector);
    fail_count++;
  end

  // PC2 is a hard input
  pc2_input: assert property (
    @(posedge CLK) disable iff (!arst_n)
    !port_out.pc_oe[2]
  ) else begin
    $error("port C bit 2 driven as an output");
    fail_count++;
  end

  tm_uf_single: assert property (
    @(posedge CLK) disable iff (!arst_n)
    tm_uf |=> !tm_uf
  ) else begin
    $error("timer underflow pulse longer than one cycle");
    fail_count++;
  end

endmodule

bind upd7800_periph upd7800_periph_assert u_periph_assert (
  .CLK        (CLK),
  .arst_n     (arst_n),
  .int_req    (int_req),
  .int_vector (int_vector),
  .port_out   (port_out),
  .tm_uf      (tm_uf)
);

`default_nettype wire

//--- upd7800_periph_tb.sv
////////////////////////////////////////
// Testbench for the uPD7800 peripheral block
// Table of steps with phase strobes and checks
////////////////////////////////////////
`default_nettype none

module upd7800_periph_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import upd7800_pkg::*;

  localparam int clk_period_ns = 8;
  localparam int reset_cycles  = 8;

  // Probe codes for reads beyond the SPR selects
  localparam int prb_pb_oe   = 8;
  localparam int prb_pc_oe   = 9;
  localparam int prb_int_req = 10;
  localparam int prb_vector  = 11;
  localparam int prb_pa      = 12;
  localparam int prb_pb      = 13;
  localparam int prb_pc      = 14;

  localparam int pin_int0 = 0;
  localparam int pin_int1 = 1;
  localparam int pin_int2 = 2;
  localparam int pin_ie   = 3;
  localparam int pin_rand = 4;

  // Expected value taken from the port model
  localparam int from_model = -1;

  typedef enum logic [3:0] {
    OP_WRITE, OP_READ, OP_PIN, OP_WAIT, OP_FETCH, OP_ACK, OP_TEST, OP_CLEAR, OP_STM
  } op_e;

  logic              CLK;
  logic              arst_n;
  spr_wr_t           spr_wr;
  spr_e              spr_rd_sel;
  logic              cp1p;
  logic              cp2n;
  logic              ie;
  logic              fetch_start;
  logic              int_ack;
  logic              stm;
  int_idx_e          irf_sel;
  logic              irf_clr;
  logic              int0;
  logic              int1;
  logic              int2;
  logic [data_w-1:0] pb_in;
  logic [data_w-1:0] pc_in;
  port_out_t         port_out;
  logic [data_w-1:0] spr_rd_data;
  logic              int_req;
  logic [data_w-1:0] int_vector;
  logic              irf_hit;

  op_e   step_op[$];
  string step_name[$];
  int    step_a[$];
  int    step_b[$];
  int    step_exp[$];

  integer seed = 32'h7111_410a;
  int     phase;
  int     cp1p_cnt;
  int     cp2n_cnt;
  int     budget_cycles;
  logic   table_ready;

  // Port register model, written alongside the DUT
  logic [7:0] mdl_pb;
  logic [7:0] mdl_mb;
  logic [7:0] mdl_pc;
  logic [7:0] mdl_mc;

  tb_clock_gen #(.period_ns(clk_period_ns), .reset_cycles(reset_cycles)) u_clk (
    .CLK    (CLK),
    .arst_n (arst_n)
  );

  upd7800_periph DUT (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .spr_wr      (spr_wr),
    .spr_rd_sel  (spr_rd_sel),
    .cp1p        (cp1p),
    .cp2n        (cp2n),
    .ie          (ie),
    .fetch_start (fetch_start),
    .int_ack     (int_ack),
    .stm         (stm),
    .irf_sel     (irf_sel),
    .irf_clr     (irf_clr),
    .int0        (int0),
    .int1        (int1),
    .int2        (int2),
    .pb_in       (pb_in),
    .pc_in       (pc_in),
    .port_out    (port_out),
    .spr_rd_data (spr_rd_data),
    .int_req     (int_req),
    .int_vector  (int_vector),
    .irf_hit     (irf_hit)
  );

  task automatic add_step(input op_e op, input string name, input int a, input int b,
                          input int exp);
    step_op.push_back(op);
    step_name.push_back(name);
    step_a.push_back(a);
    step_b.push_back(b);
    step_exp.push_back(exp);
  endtask

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    assert (act === exp) else begin
      $display("Mismatch in %s: expected %02h, actual %02h", name, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  // One CLK cycle: drop pulses, advance the four-slot phase frame
  task automatic next_cycle();
    @(posedge CLK);
    #1;
    spr_wr.we   = 1'b0;
    fetch_start = 1'b0;
    int_ack     = 1'b0;
    stm         = 1'b0;
    irf_clr     = 1'b0;
    phase = (phase + 1) % 4;
    cp1p  = (phase == 0);
    cp2n  = (phase == 2);
    if (cp1p) cp1p_cnt++;
    if (cp2n) cp2n_cnt++;
  endtask

  function automatic logic [7:0] probe_value(input int probe);
    case (probe)
      prb_pb_oe:   return port_out.pb_oe;
      prb_pc_oe:   return port_out.pc_oe;
      prb_int_req: return {7'd0, int_req};
      prb_vector:  return int_vector;
      prb_pa:      return port_out.pa;
      prb_pb:      return port_out.pb;
      prb_pc:      return port_out.pc;
      default:     return spr_rd_data;
    endcase
  endfunction

  // Input pins read as pins, output pins read as the latch
  function automatic logic [7:0] model_value(input int probe);
    logic [7:0] pc_dir;
    pc_dir = {~mdl_mc[7], 4'b1111, 1'b0, ~mdl_mc[1:0]};
    if (probe == int'(SPR_PB)) begin
      return (pb_in & mdl_mb) | (mdl_pb & ~mdl_mb);
    end
    return (pc_in & ~pc_dir) | (mdl_pc & pc_dir);
  endfunction

  task automatic apply_step(input int i);
    logic [7:0] exp;
    exp = (step_exp[i] == from_model) ? model_value(step_a[i]) : 8'(step_exp[i]);
    case (step_op[i])
      OP_WRITE: begin
        next_cycle();
        spr_wr = '{we: 1'b1, sel: spr_e'(step_a[i]), data: 8'(step_b[i])};
        case (spr_e'(step_a[i]))
          SPR_PB:  mdl_pb = 8'(step_b[i]);
          SPR_MB:  mdl_mb = 8'(step_b[i]);
          SPR_PC:  mdl_pc = 8'(step_b[i]);
          SPR_MC:  mdl_mc = 8'(step_b[i]);
          default: ;
        endcase
      end
      OP_READ: begin
        next_cycle();
        if (step_a[i] < 8) spr_rd_sel = spr_e'(step_a[i]);
        @(negedge CLK);
        check_value(step_name[i], exp, probe_value(step_a[i]));
      end
      OP_PIN: begin
        next_cycle();
        cp1p_cnt = int'(cp1p);
        case (step_a[i])
          pin_int0: int0 = step_b[i][0];
          pin_int1: int1 = step_b[i][0];
          pin_int2: int2 = step_b[i][0];
          pin_ie:   ie = step_b[i][0];
          default: begin
            pb_in = 8'($random(seed));
            pc_in = 8'($random(seed));
          end
        endcase
      end
      OP_WAIT: begin
        // Strobe counts run from the last pin change or restart
        if (step_a[i] == 0) begin
          while (cp1p_cnt < step_b[i]) next_cycle();
        end else begin
          while (cp2n_cnt < step_b[i]) next_cycle();
        end
      end
      OP_FETCH: begin
        next_cycle();
        fetch_start = 1'b1;
        next_cycle();
        @(negedge CLK);
        check_value(step_name[i], {7'd0, exp != 8'h00}, {7'd0, int_req});
        check_value(step_name[i], exp, int_vector);
      end
      OP_ACK: begin
        next_cycle();
        int_ack = 1'b1;
        next_cycle();
        @(negedge CLK);
        check_value(step_name[i], exp, {7'd0, int_req});
      end
      OP_TEST: begin
        next_cycle();
        irf_sel = int_idx_e'(step_a[i]);
        @(negedge CLK);
        check_value(step_name[i], exp, {7'd0, irf_hit});
      end
      OP_CLEAR: begin
        next_cycle();
        irf_sel = int_idx_e'(step_a[i]);
        irf_clr = 1'b1;
      end
      default: begin
        next_cycle();
        stm = 1'b1;
        // A cp2n in the restart cycle is taken by the reload
        cp2n_cnt = 0;
      end
    endcase
  endtask

  task automatic build_table();
    // Reset values
    add_step(OP_READ, "reset_mk", SPR_MK, 0, 'hFF);
    add_step(OP_READ, "reset_mb", SPR_MB, 0, 'hFF);
    add_step(OP_READ, "reset_mc", SPR_MC, 0, 'hFF);
    add_step(OP_READ, "reset_tm0", SPR_TM0, 0, 'hFF);
    add_step(OP_READ, "reset_tm1", SPR_TM1, 0, 'h0F);
    add_step(OP_READ, "reset_pb_oe", prb_pb_oe, 0, 'h00);
    add_step(OP_READ, "reset_pc_oe", prb_pc_oe, 0, 'h78);
    add_step(OP_READ, "reset_int_req", prb_int_req, 0, 0);
    // Ports
    add_step(OP_PIN, "pins_a", pin_rand, 0, 0);
    add_step(OP_WRITE, "wr_pa", SPR_PA, 'h5A, 0);
    add_step(OP_WRITE, "wr_pb", SPR_PB, 'hC3, 0);
    add_step(OP_WRITE, "wr_mb", SPR_MB, 'h0F, 0);
    add_step(OP_WRITE, "wr_pc", SPR_PC, 'hA5, 0);
    add_step(OP_WRITE, "wr_mc", SPR_MC, 'h7C, 0);
    add_step(OP_READ, "out_pa", prb_pa, 0, 'h5A);
    add_step(OP_READ, "out_pb", prb_pb, 0, 'hC3);
    add_step(OP_READ, "out_pc", prb_pc, 0, 'hA5);
    add_step(OP_READ, "dir_pb", prb_pb_oe, 0, 'hF0);
    add_step(OP_READ, "dir_pc", prb_pc_oe, 0, 'hFB);
    add_step(OP_READ, "rd_pa", SPR_PA, 0, 'h5A);
    add_step(OP_READ, "rd_mb", SPR_MB, 0, 'h0F);
    add_step(OP_READ, "rd_mc", SPR_MC, 0, 'h7C);
    add_step(OP_READ, "rd_pb_a", SPR_PB, 0, from_model);
    add_step(OP_READ, "rd_pc_a", SPR_PC, 0, from_model);
    add_step(OP_PIN, "pins_b", pin_rand, 0, 0);
    add_step(OP_READ, "rd_pb_b", SPR_PB, 0, from_model);
    add_step(OP_READ, "rd_pc_b", SPR_PC, 0, from_model);
    // INT0 level source
    add_step(OP_WRITE, "mk_int0", SPR_MK, 'hFE, 0);
    add_step(OP_PIN, "ie_on", pin_ie, 1, 0);
    add_step(OP_PIN, "int0_high", pin_int0, 1, 0);
    add_step(OP_FETCH, "int0_fetch", 0, 0, 'h04);
    add_step(OP_ACK, "int0_ack", 0, 0, 0);
    add_step(OP_PIN, "ie_off", pin_ie, 0, 0);
    add_step(OP_FETCH, "int0_no_ie", 0, 0, 'h00);
    add_step(OP_PIN, "int0_low", pin_int0, 0, 0);
    // INT1 rising, INT2 falling, the stale INT2 edge from reset is flushed first
    add_step(OP_WRITE, "mk_edges", SPR_MK, 'hD3, 0);
    add_step(OP_PIN, "int1_low", pin_int1, 0, 0);
    add_step(OP_WAIT, "flush", 0, 48, 0);
    add_step(OP_CLEAR, "clr_int2", INT_2, 0, 0);
    add_step(OP_TEST, "int2_idle", INT_2, 0, 0);
    add_step(OP_PIN, "int1_high", pin_int1, 1, 0);
    add_step(OP_PIN, "int2_fall", pin_int2, 0, 0);
    add_step(OP_WAIT, "two_ticks", 0, 24, 0);
    add_step(OP_TEST, "int1_early", INT_1, 0, 0);
    add_step(OP_TEST, "int2_early", INT_2, 0, 0);
    add_step(OP_WAIT, "four_ticks", 0, 48, 0);
    add_step(OP_TEST, "int1_pend", INT_1, 0, 1);
    add_step(OP_TEST, "int2_pend", INT_2, 0, 1);
    add_step(OP_PIN, "ie_on_b", pin_ie, 1, 0);
    add_step(OP_FETCH, "edge_fetch", 0, 0, 'h10);
    add_step(OP_CLEAR, "clr_int1", INT_1, 0, 0);
    add_step(OP_TEST, "int1_cleared", INT_1, 0, 0);
    add_step(OP_TEST, "int2_kept", INT_2, 0, 1);
    add_step(OP_ACK, "ack_int1", 0, 0, 1);
    add_step(OP_READ, "vector_int2", prb_vector, 0, 'h20);
    add_step(OP_ACK, "ack_int2", 0, 0, 0);
    // Timer reload 3 gives 32 cp2n to the first underflow
    add_step(OP_WRITE, "wr_tm0", SPR_TM0, 'h03, 0);
    add_step(OP_WRITE, "wr_tm1", SPR_TM1, 'h00, 0);
    add_step(OP_READ, "rd_tm0", SPR_TM0, 0, 'h03);
    add_step(OP_READ, "rd_tm1", SPR_TM1, 0, 'h00);
    add_step(OP_WRITE, "mk_timer", SPR_MK, 'hFD, 0);
    add_step(OP_STM, "restart", 0, 0, 0);
    add_step(OP_WAIT, "cp2n_31", 1, 31, 0);
    add_step(OP_TEST, "intt_early", INT_T, 0, 0);
    add_step(OP_WAIT, "cp2n_32", 1, 32, 0);
    add_step(OP_TEST, "intt_pend", INT_T, 0, 1);
    add_step(OP_FETCH, "timer_fetch", 0, 0, 'h08);
  endtask

  // Worst case length of the whole table
  function automatic int table_cycles();
    int total;
    total = 0;
    foreach (step_op[i]) begin
      if (step_op[i] == OP_WAIT) total += 4 * step_b[i] + 4;
      else total += 4;
    end
    return total;
  endfunction

  initial begin
    spr_wr      = '0;
    spr_rd_sel  = SPR_PA;
    cp1p        = 1'b0;
    cp2n        = 1'b0;
    ie          = 1'b0;
    fetch_start = 1'b0;
    int_ack     = 1'b0;
    stm         = 1'b0;
    irf_sel     = INT_0;
    irf_clr     = 1'b0;
    int0        = 1'b0;
    int1        = 1'b0;
    // INT2 idles high
    int2        = 1'b1;
    pb_in       = 8'h00;
    pc_in       = 8'h00;
    mdl_pb      = 8'h00;
    mdl_mb      = 8'hFF;
    mdl_pc      = 8'h00;
    mdl_mc      = 8'hFF;
    phase       = 3;
    cp1p_cnt    = 0;
    cp2n_cnt    = 0;
    table_ready = 1'b0;
    build_table();
    budget_cycles = reset_cycles + table_cycles() + 100;
    table_ready   = 1'b1;
    wait (arst_n === 1'b1);
    foreach (step_op[i]) apply_step(i);
    if (DUT.u_periph_assert.fail_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("A concurrent assertion on the DUT failed");
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

  // Bound checker failures end the run at once
  initial begin
    wait (DUT.u_periph_assert.fail_count != 0);
    $display("A concurrent assertion on the DUT failed");
    $display("*** TEST FAILED ***");
    $fatal(1);
  end

  initial begin
    wait (table_ready === 1'b1);
    #(budget_cycles * clk_period_ns);
    $display("Watchdog expired before the step table finished");
    $display("*** TEST FAILED ***");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- upd7800_pkg.sv
////////////////////////////////////////
// uPD7800 peripheral block definitions
// Widths, register selects, interrupt indices and bus structs
////////////////////////////////////////
`default_nettype none

package upd7800_pkg;

  // Widths
  localparam int data_w = 8;
  localparam int tm_w = 12;
  // Reload value plus the 3 prescaler bits
  localparam int tc_w = 15;
  localparam int div12_last = 11;
  localparam int int_vec_w = 4;

  // Special-register selects
  typedef enum logic [3:0] {
    SPR_PA  = 4'd0,
    SPR_PB  = 4'd1,
    SPR_PC  = 4'd2,
    SPR_MK  = 4'd3,
    SPR_MB  = 4'd4,
    SPR_MC  = 4'd5,
    SPR_TM0 = 4'd6,
    SPR_TM1 = 4'd7
  } spr_e;

  // Interrupt index, lowest index wins
  typedef enum logic [1:0] {
    INT_0 = 2'd0,
    INT_T = 2'd1,
    INT_1 = 2'd2,
    INT_2 = 2'd3
  } int_idx_e;

  // Vector bytes
  localparam logic [data_w-1:0] vec_int0 = 8'h04;
  localparam logic [data_w-1:0] vec_intt = 8'h08;
  localparam logic [data_w-1:0] vec_int1 = 8'h10;
  localparam logic [data_w-1:0] vec_int2 = 8'h20;

  // Port C bits 6 to 2, set bits are hard outputs
  localparam logic [4:0] pc_fixed_oe = 5'b11110;

  typedef struct packed {
    logic              we;
    spr_e              sel;
    logic [data_w-1:0] data;
  } spr_wr_t;

  typedef struct packed {
    logic [data_w-1:0] pa;
    logic [data_w-1:0] pb;
    logic [data_w-1:0] pb_oe;
    logic [data_w-1:0] pc;
    logic [data_w-1:0] pc_oe;
  } port_out_t;

  // Values seen by the core on a special-register read
  typedef struct packed {
    logic [data_w-1:0] pa;
    logic [data_w-1:0] pb;
    logic [data_w-1:0] pc;
    logic [data_w-1:0] mb;
    logic [data_w-1:0] mc;
  } port_rd_t;

endpackage

`default_nettype wire

//--- verilog.f
upd7800_pkg.sv
int_sampler.sv
int_ctrl.sv
timer_unit.sv
io_ports.sv
spr_file.sv
upd7800_periph.sv
tb_clock_gen.sv
upd7800_periph_assert.sv
upd7800_periph_tb.sv
